// ==== Bender.yml ====
package:
  name: obj_buffer

sources:
  # Package first, then the RAM, the decoder, the DMA and the top level
  - source/obj_pkg.sv
  - source/obj_dpram.sv
  - source/obj_cpu_decode.sv
  - source/obj_dma_ctrl.sv
  - source/obj_buffer.sv

  # Verification sources, top module obj_buffer_tb
  - target: simulation
    files:
      - verif/obj_buffer_assert.sv
      - verif/obj_buffer_tb.sv

// ==== flist.f ====
source/obj_pkg.sv
source/obj_dpram.sv
source/obj_cpu_decode.sv
source/obj_dma_ctrl.sv
source/obj_buffer.sv
verif/obj_buffer_assert.sv
verif/obj_buffer_tb.sv

// ==== source/obj_buffer.sv ====
/*
 * Object table double buffer, top level.
 * The CPU writes the source RAM at any time. The DMA copies it into the
 * copy RAM during vertical blank, and the object engine reads the copy.
 */

`timescale 1ns/1ps
`default_nettype none

module obj_buffer
    import obj_pkg::*;
(
    input  wire logic                 rst,
    input  wire logic                 clk,
    input  wire logic                 pxl_cen,
    // Video timing
    input  wire logic                 LVBL,
    input  wire logic                 vload,
    input  wire logic                 hinit,
    input  wire logic [7:0]           hdump,
    // CPU bus
    input  wire logic [OBJ_AW-1:0]    cpu_addr,
    input  wire logic [OBJ_DW-1:0]    cpu_dout,
    input  wire logic [OBJ_BYTES-1:0] cpu_dsn,
    input  wire logic                 cpu_rnw,
    input  wire logic                 objram_cs,
    output logic      [OBJ_DW-1:0]    obj_dout,
    // Object engine table port
    input  wire logic [OBJ_AW-1:0]    tbl_addr,
    output logic      [OBJ_DW-1:0]    tbl_dout,
    // Copy trigger
    input  wire logic                 obj_copy,
    input  wire logic                 mixpsel
);

    logic [OBJ_BYTES-1:0] cpu_we;
    logic [OBJ_AW-1:0]    scan_addr;
    logic [OBJ_AW-1:0]    copy_addr;
    logic                 copy_we;
    logic [OBJ_DW-1:0]    src_q;

    obj_cpu_decode u_decode (
        .objram_cs (objram_cs),
        .cpu_rnw   (cpu_rnw),
        .cpu_dsn   (cpu_dsn),
        .cpu_we    (cpu_we)
    );

    obj_dma_ctrl u_dma (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .LVBL      (LVBL),
        .vload     (vload),
        .hinit     (hinit),
        .hdump     (hdump),
        .obj_copy  (obj_copy),
        .mixpsel   (mixpsel),
        .src_q     (src_q),
        .scan_addr (scan_addr),
        .copy_addr (copy_addr),
        .copy_we   (copy_we)
    );

    // Source table, CPU on port 0 and scan reads on port 1
    obj_dpram #(.AW(OBJ_AW)) u_src (
        .clk   (clk),
        .addr0 (cpu_addr),
        .data0 (cpu_dout),
        .we0   (cpu_we),
        .q0    (obj_dout),
        .addr1 (scan_addr),
        .data1 ({OBJ_DW{1'b0}}),
        .we1   ({OBJ_BYTES{1'b0}}),
        .q1    (src_q)
    );

    // Copy table, DMA writes on port 0 and engine reads on port 1
    obj_dpram #(.AW(OBJ_AW)) u_copy (
        .clk   (clk),
        .addr0 (copy_addr),
        .data0 (src_q),
        .we0   ({OBJ_BYTES{copy_we}}),
        .q0    (),
        .addr1 (tbl_addr),
        .data1 ({OBJ_DW{1'b0}}),
        .we1   ({OBJ_BYTES{1'b0}}),
        .q1    (tbl_dout)
    );

endmodule

`default_nettype wire

// ==== source/obj_cpu_decode.sv ====
/*
 * CPU access decoder for the object RAM.
 * Sorts each bus cycle into none, read or write and turns the data strobes
 * of a write into active-high byte enables.
 */

`timescale 1ns/1ps
`default_nettype none

module obj_cpu_decode
    import obj_pkg::*;
(
    input  wire logic                 objram_cs,
    input  wire logic                 cpu_rnw,
    // Active-low data strobes, one per byte lane
    input  wire logic [OBJ_BYTES-1:0] cpu_dsn,
    // Byte write enables for the source RAM
    output logic      [OBJ_BYTES-1:0] cpu_we
);

    cpu_acc_t acc;

    // Cycle kind
    always_comb begin
        if (!objram_cs) begin
            acc = ACC_NONE;
        end else if (cpu_rnw) begin
            acc = ACC_READ;
        end else begin
            acc = ACC_WRITE;
        end
    end

    // Lane enables
    always_comb begin
        case (acc)
            ACC_WRITE: begin
                // Strobe low means the lane takes part
                cpu_we = ~cpu_dsn;
            end
            ACC_READ: begin
                // Read data comes from q0 with no write
                cpu_we = '0;
            end
            default: begin
                cpu_we = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/obj_dma_ctrl.sv ====
/*
 * Object table DMA controller.
 * Keeps the line counter, arms on obj_copy and copies the source table
 * into the copy RAM during vertical blank. The copy address either follows
 * the scan or takes its page from the previous pixel's data.
 */

`timescale 1ns/1ps
`default_nettype none

module obj_dma_ctrl
    import obj_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              pxl_cen,
    // Video timing
    input  wire logic              LVBL,
    input  wire logic              vload,
    input  wire logic              hinit,
    input  wire logic [7:0]        hdump,
    // Copy control
    input  wire logic              obj_copy,
    input  wire logic              mixpsel,
    // Source RAM read data
    input  wire logic [OBJ_DW-1:0] src_q,
    output logic      [OBJ_AW-1:0] scan_addr,
    output logic      [OBJ_AW-1:0] copy_addr,
    output logic                   copy_we
);

    dma_state_t          state;
    logic [LINE_W-1:0]   line_cnt;
    logic                line_msb_q;
    logic [OBJ_AW-3:0]   page_latch;
    logic [OBJ_AW-3:0]   page;
    logic                start_copy;

    // Back at line 8 after a full lap, never on the preset
    assign start_copy = !LVBL && (line_cnt == DMA_START_LINE) && !line_msb_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= DMA_IDLE;
            line_cnt   <= '0;
            line_msb_q <= 1'b0;
            page_latch <= '0;
        end else begin
            line_msb_q <= line_cnt[LINE_W-1];
            if (vload) begin
                line_cnt <= DMA_START_LINE;
            end else if (hinit && pxl_cen) begin
                line_cnt <= line_cnt + 1'b1;
            end
            // Low byte of the previous pixel for indirect copies
            if (pxl_cen) begin
                page_latch <= src_q[OBJ_AW-3:0];
            end
            case (state)
                DMA_IDLE: begin
                    if (obj_copy) state <= DMA_ARMED;
                end
                DMA_ARMED: begin
                    // vload here keeps the request pending
                    if (!vload && start_copy) state <= DMA_COPY;
                end
                DMA_COPY: begin
                    if (vload) state <= DMA_IDLE;
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

    // Scan order, columns inverted within each group
    assign scan_addr = {line_cnt, hdump[7:4], ~hdump[3:2]};
    assign page      = mixpsel ? page_latch : scan_addr[OBJ_AW-1:2];
    assign copy_addr = {page, ~hdump[3:2]};
    assign copy_we   = (state == DMA_COPY);

endmodule

`default_nettype wire

// ==== source/obj_dpram.sv ====
/*
 * Dual-port object RAM.
 * Both ports run on clk, write per byte lane and give read-first data one
 * cycle after the address.
 */

`timescale 1ns/1ps
`default_nettype none

module obj_dpram
    import obj_pkg::*;
#(
    parameter int AW = OBJ_AW
) (
    input  wire logic                 clk,
    // Port 0
    input  wire logic [AW-1:0]        addr0,
    input  wire logic [OBJ_DW-1:0]    data0,
    input  wire logic [OBJ_BYTES-1:0] we0,
    output logic      [OBJ_DW-1:0]    q0,
    // Port 1
    input  wire logic [AW-1:0]        addr1,
    input  wire logic [OBJ_DW-1:0]    data1,
    input  wire logic [OBJ_BYTES-1:0] we1,
    output logic      [OBJ_DW-1:0]    q1
);

    logic [OBJ_DW-1:0] mem [2**AW];

    always_ff @(posedge clk) begin
        // Old contents come out on a same-cycle write
        q0 <= mem[addr0];
        q1 <= mem[addr1];
        for (int b = 0; b < OBJ_BYTES; b++) begin
            if (we0[b]) begin
                mem[addr0][b*8 +: 8] <= data0[b*8 +: 8];
            end
            // Port 1 wins a clash on the same byte
            if (we1[b]) begin
                mem[addr1][b*8 +: 8] <= data1[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/obj_pkg.sv ====
/*
 * Object table buffer package.
 * This package holds the RAM geometry, the scan line constants and the enums
 * that the DMA controller and the CPU decoder share.
 */

`default_nettype none

package obj_pkg;

    // Word address width of each object RAM (1024 words)
    localparam int OBJ_AW = 10;

    // Data width and byte lanes
    localparam int OBJ_DW    = 16;
    localparam int OBJ_BYTES = 2;

    // Line counter (v14 on the board) wraps every 16 lines
    localparam int LINE_W = 4;

    // Line where the copy starts, also the vload preset
    localparam logic [LINE_W-1:0] DMA_START_LINE = 4'd8;

    // DMA sequencing
    typedef enum logic [1:0] {
        DMA_IDLE  = 2'd0,
        DMA_ARMED = 2'd1,
        DMA_COPY  = 2'd2
    } dma_state_t;

    // CPU bus cycle kinds
    typedef enum logic [1:0] {
        ACC_NONE  = 2'd0,
        ACC_READ  = 2'd1,
        ACC_WRITE = 2'd2
    } cpu_acc_t;

endpackage

`default_nettype wire

// ==== verif/obj_buffer_assert.sv ====
/*
 * Assertions on the object table DMA controller.
 * Checks the copy enable, the end of a copy, the entry into COPY and the
 * line counter preset.
 */

`timescale 1ns/1ps
`default_nettype none

module obj_buffer_assert
    import obj_pkg::*;
(
    input wire logic              clk,
    input wire logic              rst,
    input wire logic              LVBL,
    input wire logic              vload,
    input wire logic              copy_we,
    input wire dma_state_t        state,
    input wire logic [LINE_W-1:0] line_cnt
);

    int fail_count = 0;

    // Copy RAM writes open only on the return to line 8 in blank
    a_we_opens_at_start: assert property (@(posedge clk) disable iff (rst)
        $rose(copy_we) |-> $past(state == DMA_ARMED && !LVBL
                                 && line_cnt == DMA_START_LINE))
        else begin
            $error("copy_we rose outside the start of a copy");
            fail_count++;
        end

    // Writes close only on vload in COPY
    a_we_closes_on_vload: assert property (@(posedge clk) disable iff (rst)
        $fell(copy_we) |-> $past(state == DMA_COPY && vload))
        else begin
            $error("copy_we fell without vload in COPY");
            fail_count++;
        end

    a_vload_ends_copy: assert property (@(posedge clk) disable iff (rst)
        (state == DMA_COPY && vload) |=> state == DMA_IDLE)
        else begin
            $error("vload did not end the copy");
            fail_count++;
        end

    // No entry into COPY outside vertical blank
    a_copy_in_blank: assert property (@(posedge clk) disable iff (rst)
        (state == DMA_ARMED && LVBL) |=> state != DMA_COPY)
        else begin
            $error("copy started while LVBL was high");
            fail_count++;
        end

    a_vload_preset: assert property (@(posedge clk) disable iff (rst)
        vload |=> line_cnt == DMA_START_LINE)
        else begin
            $error("line counter not preset by vload");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== verif/obj_buffer_tb.sv ====
/*
 * Testbench for the object table double buffer.
 * Generates the video timing, plays the CPU, keeps a pixel-level model of
 * both tables and applies a table of test rows.
 */

`timescale 1ns/1ps
`default_nettype none

module obj_buffer_tb
    import obj_pkg::*;
();

    localparam int PIX_CYC   = 4;
    localparam int FRAME_CYC = 40 * 256 * PIX_CYC;
    localparam int NUM_ROWS  = 9;

    typedef enum logic [1:0] {K_BYTES, K_FILL, K_FRAMES} test_kind_t;

    typedef struct packed {
        test_kind_t kind;
        logic       mix;
        logic       pulse;
        logic [5:0] pulse_line;
        logic [1:0] frames;
        dma_state_t exp_state;
    } row_t;

    // kind, mixpsel, obj_copy pulse, line of the pulse, frames, state at the end
    localparam row_t ROWS [NUM_ROWS] = '{
        '{K_BYTES,  1'b0, 1'b0, 6'd0,  2'd0, DMA_IDLE},
        '{K_FILL,   1'b0, 1'b0, 6'd0,  2'd0, DMA_IDLE},
        '{K_FRAMES, 1'b0, 1'b1, 6'd0,  2'd1, DMA_IDLE},
        '{K_FILL,   1'b0, 1'b0, 6'd0,  2'd0, DMA_IDLE},
        '{K_FRAMES, 1'b0, 1'b0, 6'd0,  2'd1, DMA_IDLE},
        '{K_FRAMES, 1'b1, 1'b1, 6'd0,  2'd1, DMA_IDLE},
        '{K_FILL,   1'b0, 1'b0, 6'd0,  2'd0, DMA_IDLE},
        '{K_FRAMES, 1'b0, 1'b1, 6'd34, 2'd1, DMA_ARMED},
        '{K_FRAMES, 1'b0, 1'b0, 6'd0,  2'd1, DMA_IDLE}
    };

    logic                 clk;
    logic                 rst;
    logic                 pxl_cen;
    logic                 LVBL;
    logic                 vload;
    logic                 hinit;
    logic [7:0]           hdump;
    logic [OBJ_AW-1:0]    cpu_addr;
    logic [OBJ_DW-1:0]    cpu_dout;
    logic [OBJ_BYTES-1:0] cpu_dsn;
    logic                 cpu_rnw;
    logic                 objram_cs;
    logic [OBJ_DW-1:0]    obj_dout;
    logic [OBJ_AW-1:0]    tbl_addr;
    logic [OBJ_DW-1:0]    tbl_dout;
    logic                 obj_copy;
    logic                 mixpsel;

    // Reference model: source mirror, expected copy table, DMA view
    logic [OBJ_DW-1:0]    mirror [2**OBJ_AW];
    logic [OBJ_DW-1:0]    copy_model [2**OBJ_AW];
    logic                 copy_valid [2**OBJ_AW];
    dma_state_t           m_state;
    logic [LINE_W-1:0]    m_line;
    logic                 m_prev_msb;
    logic [7:0]           m_latch;
    logic [31:0]          seed;
    int                   errors;
    int                   checks;
    int                   cycles;

    obj_buffer u_obj_buffer (.*);

    bind obj_dma_ctrl obj_buffer_assert u_assert (
        .clk (clk), .rst (rst), .LVBL (LVBL), .vload (vload),
        .copy_we (copy_we), .state (state), .line_cnt (line_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit from the frames in the table, 20% margin for CPU work
    initial begin
        int total;
        int limit;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += ROWS[i].frames;
        end
        limit = total * FRAME_CYC * 12 / 10;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: test still running after %0d cycles", limit);
                $display("Some tests failed");
                $finish;
            end
        end
    end

    function automatic logic [OBJ_DW-1:0] rand_word();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[31:16];
    endfunction

    task automatic check_word(input string name, input logic [OBJ_DW-1:0] got,
                              input logic [OBJ_DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_state(input string name, input dma_state_t got,
                               input dma_state_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // One bus cycle; writes merge into the mirror per byte lane
    task automatic cpu_access(input cpu_acc_t acc, input logic [OBJ_AW-1:0] addr,
                              input logic [OBJ_DW-1:0] data,
                              input logic [OBJ_BYTES-1:0] dsn);
        cpu_addr  = addr;
        cpu_dout  = data;
        cpu_dsn   = dsn;
        cpu_rnw   = (acc != ACC_WRITE);
        objram_cs = (acc != ACC_NONE);
        @(posedge clk);
        #1;
        objram_cs = 1'b0;
        cpu_rnw   = 1'b1;
        cpu_dsn   = '1;
        if (acc == ACC_WRITE) begin
            for (int b = 0; b < OBJ_BYTES; b++) begin
                if (!dsn[b]) mirror[addr][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    // Every strobe pattern, full word first so no lane stays unknown
    task automatic byte_test();
        logic [OBJ_AW-1:0] addr;
        for (int i = 0; i < 8; i++) begin
            addr = OBJ_AW'(i * 131 + 5);
            for (int d = 0; d < 4; d++) begin
                cpu_access(ACC_WRITE, addr, rand_word(), d[1:0]);
                cpu_access(ACC_READ, addr, '0, 2'b00);
                check_word($sformatf("obj_dout[%03h]", addr), obj_dout, mirror[addr]);
            end
        end
    endtask

    // One pixel of four clocks, pxl_cen on the last
    task automatic run_pixel(input int line, input logic [7:0] h, input logic pulse);
        logic [OBJ_AW-1:0] scan;
        logic [OBJ_AW-3:0] page;
        scan = {m_line, h[7:4], ~h[3:2]};
        // Copy begins when the counter comes back to 8 in blank
        if (h == 8'd0 && m_state == DMA_ARMED && line >= 24
            && m_line == DMA_START_LINE && !m_prev_msb) begin
            m_state = DMA_COPY;
        end
        if (pulse && m_state == DMA_IDLE) m_state = DMA_ARMED;
        for (int k = 0; k < PIX_CYC; k++) begin
            hdump    = h;
            hinit    = (h == 8'hff);
            LVBL     = (line < 24);
            pxl_cen  = (k == PIX_CYC - 1);
            vload    = (k == PIX_CYC - 1) && (h == 8'hff) && (line == 38);
            obj_copy = pulse && (k == 0);
            @(posedge clk);
            #1;
        end
        // Last write of the pixel carries the word at its scan address
        page = mixpsel ? m_latch : scan[OBJ_AW-1:2];
        if (m_state == DMA_COPY) begin
            copy_model[{page, ~h[3:2]}] = mirror[scan];
            copy_valid[{page, ~h[3:2]}] = 1'b1;
        end
        m_latch = mirror[scan][7:0];
        if (h == 8'hff) begin
            m_prev_msb = m_line[LINE_W-1];
            if (line == 38) begin
                m_line = DMA_START_LINE;
                if (m_state == DMA_COPY) m_state = DMA_IDLE;
            end else begin
                m_line = m_line + 1'b1;
            end
        end
    endtask

    // Reads back every table entry the model expects to be written
    task automatic check_table();
        for (int a = 0; a < 2**OBJ_AW; a++) begin
            if (copy_valid[a]) begin
                tbl_addr = a[OBJ_AW-1:0];
                @(posedge clk);
                #1;
                check_word($sformatf("tbl_dout[%03h]", a), tbl_dout, copy_model[a]);
            end
        end
    endtask

    task automatic run_row(input row_t r);
        mixpsel = r.mix;
        case (r.kind)
            K_BYTES: byte_test();
            K_FILL: begin
                for (int a = 0; a < 2**OBJ_AW; a++) begin
                    cpu_access(ACC_WRITE, a[OBJ_AW-1:0], rand_word(), 2'b00);
                end
            end
            default: begin
                for (int f = 0; f < r.frames; f++) begin
                    for (int line = 0; line < 40; line++) begin
                        for (int h = 0; h < 256; h++) begin
                            run_pixel(line, h[7:0], r.pulse && f == 0 &&
                                      line == r.pulse_line && h == 0);
                        end
                    end
                end
                pxl_cen = 1'b0;
                hinit   = 1'b0;
                check_state("state", u_obj_buffer.u_dma.state, r.exp_state);
                check_table();
            end
        endcase
    endtask

    initial begin
        rst       = 1'b1;
        pxl_cen   = 1'b0;
        LVBL      = 1'b1;
        vload     = 1'b0;
        hinit     = 1'b0;
        hdump     = '0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        cpu_dsn   = '1;
        cpu_rnw   = 1'b1;
        objram_cs = 1'b0;
        tbl_addr  = '0;
        obj_copy  = 1'b0;
        mixpsel   = 1'b0;
        seed      = 32'd22367;
        errors    = 0;
        checks    = 0;
        m_state    = DMA_IDLE;
        m_line     = '0;
        m_prev_msb = 1'b0;
        m_latch    = '0;
        for (int a = 0; a < 2**OBJ_AW; a++) begin
            copy_valid[a] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(ROWS[i]);
        end
        errors += u_obj_buffer.u_dma.u_assert.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
